// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mem_subsys_tb \
		-f filelist.f -o simv
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	! grep -q "\*\*\* FAILED \*\*\*" sim.log
	grep -q "\*\*\* PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
+incdir+src
src/mem_pkg.sv
src/mem_bus_if.sv
src/bus_switch.sv
src/bus2sram.sv
src/sram_bank.sv
src/exit_monitor.sv
src/mem_subsys_top.sv
tb/mem_subsys_checker.sv
tb/mem_scoreboard.sv
tb/mem_subsys_tb.sv

// ==== src/bus2sram.sv ====
// Bus to SRAM strobe bridge, one request at a time
// Assumes a one-cycle registered SRAM read; write responses return zero
`timescale 1ns/1ns
`include "mem_defines.svh"

module bus2sram (
  input  logic                   clk_i,
  input  logic                   rst_i,
  mem_bus_if.sub                 bus,
  output logic                   sram_req_o,
  output logic                   sram_we_o,
  output logic [`MEM_IDX_W-1:0]  sram_addr_o,
  output logic [`MEM_BE_W-1:0]   sram_be_o,
  output logic [`MEM_DATA_W-1:0] sram_wdata_o,
  input  logic [`MEM_DATA_W-1:0] sram_rdata_i
);

  logic                   pending_q;
  logic                   is_read_q;
  logic                   first_q;
  logic [`MEM_DATA_W-1:0] rdata_q;
  logic                   accept;
  logic                   rsp_done;

  // ------------------------------------------------------------------------
  // Request to strobe
  // ------------------------------------------------------------------------

  // Blocked while a response waits to be taken
  assign bus.req_ready = ~pending_q;
  assign accept        = bus.req_valid & bus.req_ready;

  // Strobe goes out in the acceptance cycle
  assign sram_req_o   = accept;
  assign sram_we_o    = bus.req_we;
  assign sram_addr_o  = bus.req_addr[`MEM_OFS_W +: `MEM_IDX_W];
  assign sram_be_o    = bus.req_be;
  assign sram_wdata_o = bus.req_wdata;

  // ------------------------------------------------------------------------
  // Response
  // ------------------------------------------------------------------------

  assign bus.rsp_valid = pending_q;
  assign rsp_done      = bus.rsp_valid & bus.rsp_ready;

  // SRAM output is fresh only in the first response cycle,
  // after that the captured copy is used
  always_comb begin
    if (!is_read_q) begin
      bus.rsp_rdata = '0;
    end else if (first_q) begin
      bus.rsp_rdata = sram_rdata_i;
    end else begin
      bus.rsp_rdata = rdata_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
      is_read_q <= 1'b0;
      first_q   <= 1'b0;
    end else begin
      first_q <= accept;
      if (accept) begin
        pending_q <= 1'b1;
        is_read_q <= ~bus.req_we;
      end else if (rsp_done) begin
        pending_q <= 1'b0;
      end
    end
  end

  // Read data capture
  always_ff @(posedge clk_i) begin
    if (first_q) begin
      rdata_q <= sram_rdata_i;
    end
  end

endmodule

// ==== src/bus_switch.sv ====
// Routes requests to internal SRAM or the external slave port
// One transaction in flight at a time; no new request until the response is taken
`timescale 1ns/1ns
`include "mem_defines.svh"

module bus_switch (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   switch_active_i,
  mem_bus_if.sub                 up,
  mem_bus_if.mgr                 int_bus,
  output logic                   ext_req_valid_o,
  output logic                   ext_req_we_o,
  output logic [`MEM_ADDR_W-1:0] ext_req_addr_o,
  output logic [`MEM_BE_W-1:0]   ext_req_be_o,
  output logic [`MEM_DATA_W-1:0] ext_req_wdata_o,
  input  logic                   ext_req_ready_i,
  input  logic                   ext_rsp_valid_i,
  input  logic [`MEM_DATA_W-1:0] ext_rsp_rdata_i,
  output logic                   ext_rsp_ready_o
);
  import mem_pkg::*;

  logic   busy_q;
  route_e owner_q;
  logic   lock_q;
  route_e lock_route_q;
  route_e req_route;
  logic   presented;
  logic   tgt_ready;
  logic   accept;
  logic   rsp_done;

  // ------------------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------------------

  // Route is frozen once a request is shown to a target and not yet taken,
  // so a toggling select never pulls valid away from a waiting target
  assign req_route = lock_q ? lock_route_q : (switch_active_i ? ROUTE_EXT : ROUTE_INT);

  assign presented = up.req_valid & ~busy_q;
  assign tgt_ready = (req_route == ROUTE_EXT) ? ext_req_ready_i : int_bus.req_ready;

  // Idle switch shows ready until a request arrives
  assign up.req_ready = ~busy_q & (~up.req_valid | tgt_ready);
  assign accept       = up.req_valid & up.req_ready;

  assign int_bus.req_valid = presented & (req_route == ROUTE_INT);
  assign int_bus.req_we    = up.req_we;
  assign int_bus.req_addr  = up.req_addr;
  assign int_bus.req_be    = up.req_be;
  assign int_bus.req_wdata = up.req_wdata;

  assign ext_req_valid_o = presented & (req_route == ROUTE_EXT);
  assign ext_req_we_o    = up.req_we;
  assign ext_req_addr_o  = up.req_addr;
  assign ext_req_be_o    = up.req_be;
  assign ext_req_wdata_o = up.req_wdata;

  // ------------------------------------------------------------------------
  // Response side, steered by the owner register
  // ------------------------------------------------------------------------

  assign up.rsp_valid = busy_q & ((owner_q == ROUTE_EXT) ? ext_rsp_valid_i : int_bus.rsp_valid);
  assign up.rsp_rdata = (owner_q == ROUTE_EXT) ? ext_rsp_rdata_i : int_bus.rsp_rdata;

  assign int_bus.rsp_ready = busy_q & (owner_q == ROUTE_INT) & up.rsp_ready;
  assign ext_rsp_ready_o   = busy_q & (owner_q == ROUTE_EXT) & up.rsp_ready;

  assign rsp_done = up.rsp_valid & up.rsp_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q       <= 1'b0;
      owner_q      <= ROUTE_INT;
      lock_q       <= 1'b0;
      lock_route_q <= ROUTE_INT;
    end else begin
      lock_q       <= presented & ~accept;
      lock_route_q <= req_route;
      if (accept) begin
        busy_q  <= 1'b1;
        owner_q <= req_route;
      end else if (rsp_done) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

// ==== src/exit_monitor.sv ====
// Watches SRAM writes to the tohost word and reports end of test
// First write with done set wins; the flag holds until reset
`timescale 1ns/1ns
`include "mem_defines.svh"

module exit_monitor (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   sram_req_i,
  input  logic                   sram_we_i,
  input  logic [`MEM_IDX_W-1:0]  sram_addr_i,
  input  logic [`MEM_DATA_W-1:0] sram_wdata_i,
  output logic                   exit_valid_o,
  output logic [`MEM_DATA_W-2:0] exit_code_o
);
  import mem_pkg::*;

  localparam logic [`MEM_ADDR_W-1:0] TOHOST_ADDR = `MEM_TOHOST_ADDR;
  localparam logic [`MEM_IDX_W-1:0]  TOHOST_IDX  = TOHOST_ADDR[`MEM_OFS_W +: `MEM_IDX_W];

  exit_word_u wdata_u;
  logic       hit;

  assign wdata_u.raw = sram_wdata_i;

  // Any byte-enable pattern counts, only done matters
  assign hit = sram_req_i & sram_we_i & (sram_addr_i == TOHOST_IDX) & wdata_u.fields.done;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_o <= 1'b0;
    end else if (hit) begin
      exit_valid_o <= 1'b1;
    end
  end

  // Code frozen after the first exit
  always_ff @(posedge clk_i) begin
    if (hit && !exit_valid_o) begin
      exit_code_o <= wdata_u.fields.code;
    end
  end

endmodule

// ==== src/mem_bus_if.sv ====
// Single-beat request/response bus, valid/ready on each channel
// No bursts or IDs; every request gets exactly one response
`timescale 1ns/1ns
`include "mem_defines.svh"

interface mem_bus_if;

  // Request channel
  logic                   req_valid;
  logic                   req_ready;
  logic                   req_we;
  logic [`MEM_ADDR_W-1:0] req_addr;
  logic [`MEM_BE_W-1:0]   req_be;
  logic [`MEM_DATA_W-1:0] req_wdata;

  // Response channel, write responses carry zero data
  logic                   rsp_valid;
  logic                   rsp_ready;
  logic [`MEM_DATA_W-1:0] rsp_rdata;

  modport mgr (
    output req_valid, req_we, req_addr, req_be, req_wdata, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata
  );

  modport sub (
    input  req_valid, req_we, req_addr, req_be, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

// ==== src/mem_defines.svh ====
// Widths and memory map shared by the whole subsystem
// Word size is fixed at 32 bits and addresses above the SRAM size alias
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_BE_W   4

// SRAM geometry
`define MEM_WORDS  1024
// Word index taken from byte address bits 11:2
`define MEM_IDX_W  10
`define MEM_OFS_W  2

// End-of-test mailbox, byte address inside the internal SRAM
// A write with bit 0 set here ends the test
`define MEM_TOHOST_ADDR 32'h0000_0FF0

`endif

// ==== src/mem_pkg.sv ====
// Types shared by the subsystem and its checkers
// Exit word layout is code in bits 31:1 and done in bit 0
`include "mem_defines.svh"

package mem_pkg;

  // ------------------------------------------------------------------------
  // Tohost exit word
  // ------------------------------------------------------------------------

  // Field view of a tohost write
  typedef struct packed {
    logic [`MEM_DATA_W-2:0] code;
    logic                   done;
  } exit_fields_t;

  // Same data word, seen raw by the SRAM and decoded by the exit logic
  typedef union packed {
    logic [`MEM_DATA_W-1:0] raw;
    exit_fields_t           fields;
  } exit_word_u;

  // ------------------------------------------------------------------------
  // Response ownership
  // ------------------------------------------------------------------------

  // Which target owes the outstanding response
  typedef enum logic {
    ROUTE_INT = 1'b0,
    ROUTE_EXT = 1'b1
  } route_e;

endpackage

// ==== src/mem_subsys_top.sv ====
// Memory test subsystem: switch, SRAM bridge, SRAM bank and exit monitor
// Internal latency is one cycle; external latency is set by the slave
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_subsys_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   switch_active_i,
  // Upstream bus
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_we_i,
  input  logic [`MEM_ADDR_W-1:0] req_addr_i,
  input  logic [`MEM_BE_W-1:0]   req_be_i,
  input  logic [`MEM_DATA_W-1:0] req_wdata_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`MEM_DATA_W-1:0] rsp_rdata_o,
  // External slave port
  output logic                   ext_req_valid_o,
  input  logic                   ext_req_ready_i,
  output logic                   ext_req_we_o,
  output logic [`MEM_ADDR_W-1:0] ext_req_addr_o,
  output logic [`MEM_BE_W-1:0]   ext_req_be_o,
  output logic [`MEM_DATA_W-1:0] ext_req_wdata_o,
  input  logic                   ext_rsp_valid_i,
  output logic                   ext_rsp_ready_o,
  input  logic [`MEM_DATA_W-1:0] ext_rsp_rdata_i,
  // End of test
  output logic                   exit_valid_o,
  output logic [`MEM_DATA_W-2:0] exit_code_o
);

  mem_bus_if up_bus ();
  mem_bus_if int_bus ();

  logic                   sram_req;
  logic                   sram_we;
  logic [`MEM_IDX_W-1:0]  sram_addr;
  logic [`MEM_BE_W-1:0]   sram_be;
  logic [`MEM_DATA_W-1:0] sram_wdata;
  logic [`MEM_DATA_W-1:0] sram_rdata;

  // ------------------------------------------------------------------------
  // Plain ports onto the upstream bus
  // ------------------------------------------------------------------------

  assign up_bus.req_valid = req_valid_i;
  assign up_bus.req_we    = req_we_i;
  assign up_bus.req_addr  = req_addr_i;
  assign up_bus.req_be    = req_be_i;
  assign up_bus.req_wdata = req_wdata_i;
  assign up_bus.rsp_ready = rsp_ready_i;
  assign req_ready_o      = up_bus.req_ready;
  assign rsp_valid_o      = up_bus.rsp_valid;
  assign rsp_rdata_o      = up_bus.rsp_rdata;

  bus_switch u_switch (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .switch_active_i (switch_active_i),
    .up              (up_bus),
    .int_bus         (int_bus),
    .ext_req_valid_o (ext_req_valid_o),
    .ext_req_we_o    (ext_req_we_o),
    .ext_req_addr_o  (ext_req_addr_o),
    .ext_req_be_o    (ext_req_be_o),
    .ext_req_wdata_o (ext_req_wdata_o),
    .ext_req_ready_i (ext_req_ready_i),
    .ext_rsp_valid_i (ext_rsp_valid_i),
    .ext_rsp_rdata_i (ext_rsp_rdata_i),
    .ext_rsp_ready_o (ext_rsp_ready_o)
  );

  // ------------------------------------------------------------------------
  // Internal memory path
  // ------------------------------------------------------------------------

  bus2sram u_bridge (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .bus          (int_bus),
    .sram_req_o   (sram_req),
    .sram_we_o    (sram_we),
    .sram_addr_o  (sram_addr),
    .sram_be_o    (sram_be),
    .sram_wdata_o (sram_wdata),
    .sram_rdata_i (sram_rdata)
  );

  sram_bank u_sram (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .be_i    (sram_be),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  // Snoops the strobes, so tohost writes are also stored
  exit_monitor u_exit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .sram_req_i   (sram_req),
    .sram_we_i    (sram_we),
    .sram_addr_i  (sram_addr),
    .sram_wdata_i (sram_wdata),
    .exit_valid_o (exit_valid_o),
    .exit_code_o  (exit_code_o)
  );

endmodule

// ==== src/sram_bank.sv ====
// Single-port word SRAM with byte enables and a registered read
// Contents start at zero in simulation and are never reset
`timescale 1ns/1ns
`include "mem_defines.svh"

module sram_bank (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`MEM_IDX_W-1:0]  addr_i,
  input  logic [`MEM_BE_W-1:0]   be_i,
  input  logic [`MEM_DATA_W-1:0] wdata_i,
  output logic [`MEM_DATA_W-1:0] rdata_o
);

  logic [`MEM_DATA_W-1:0] mem_q [`MEM_WORDS] = '{default: '0};

  // Byte lanes written under their enable
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < `MEM_BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read data appears the cycle after the strobe, held otherwise
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// ==== tb/mem_scoreboard.sv ====
// Reference model of internal and external memory checked on every edge
// Route is taken from switch_active_i at acceptance and the stimulus holds it stable
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_scoreboard (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   switch_active_i,
  input  logic                   req_valid_i,
  input  logic                   req_ready_i,
  input  logic                   req_we_i,
  input  logic [`MEM_ADDR_W-1:0] req_addr_i,
  input  logic [`MEM_BE_W-1:0]   req_be_i,
  input  logic [`MEM_DATA_W-1:0] req_wdata_i,
  input  logic                   rsp_valid_i,
  input  logic                   rsp_ready_i,
  input  logic [`MEM_DATA_W-1:0] rsp_rdata_i,
  input  logic                   ext_req_valid_i,
  input  logic                   ext_req_we_i,
  input  logic [`MEM_ADDR_W-1:0] ext_req_addr_i,
  input  logic [`MEM_BE_W-1:0]   ext_req_be_i,
  input  logic [`MEM_DATA_W-1:0] ext_req_wdata_i,
  input  logic                   ext_rsp_ready_i,
  input  logic                   exit_valid_i,
  input  logic [`MEM_DATA_W-2:0] exit_code_i,
  output int                     err_cnt_o,
  output int                     acc_cnt_o,
  output int                     rsp_cnt_o
);
  import mem_pkg::*;

  logic [`MEM_DATA_W-1:0] int_mem [`MEM_WORDS] = '{default: '0};
  logic [`MEM_DATA_W-1:0] ext_mem [`MEM_WORDS] = '{default: '0};
  logic                   rst_q;
  logic                   pend;
  logic                   pend_ext;
  logic                   pend_before;
  logic                   exp_ext_ready;
  logic [`MEM_DATA_W-1:0] exp_rdata;
  logic                   exp_exit;
  logic [`MEM_DATA_W-2:0] exp_code;
  logic [`MEM_IDX_W-1:0]  idx;
  route_e                 route;
  exit_word_u             wword;

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("ERROR %s expected %h actual %h", name, exp, act);
    err_cnt_o++;
  endtask

  task automatic report_failure(string what);
    $display("ERROR %s", what);
    err_cnt_o++;
  endtask

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wd,
                                              logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = wd[b*8 +: 8];
    end
    return res;
  endfunction

  always @(posedge clk_i) begin
    rst_q <= rst_i;
    if (rst_i) begin
      pend      = 1'b0;
      pend_ext  = 1'b0;
      exp_exit  = 1'b0;
      err_cnt_o = 0;
      acc_cnt_o = 0;
      rsp_cnt_o = 0;
    end else begin
      if (rst_q && (!req_ready_i || rsp_valid_i || ext_req_valid_i || exit_valid_i)) begin
        report_failure("outputs were not idle right after reset");
      end
      if (exit_valid_i !== exp_exit) report_mismatch("exit_valid", exp_exit, exit_valid_i);
      if (exp_exit && exit_code_i !== exp_code) begin
        report_mismatch("exit_code", exp_code, exit_code_i);
      end
      // Upstream ready reaches the external slave only while it owes the response
      exp_ext_ready = pend && pend_ext && rsp_ready_i;
      if (ext_rsp_ready_i !== exp_ext_ready) begin
        report_mismatch("ext_rsp_ready", exp_ext_ready, ext_rsp_ready_i);
      end
      pend_before = pend;
      if (pend && req_ready_i) report_failure("request ready while a response is pending");
      if (rsp_valid_i) begin
        if (!pend) begin
          report_failure("response without an accepted request");
        end else if (rsp_rdata_i !== exp_rdata) begin
          report_mismatch("rsp_rdata", exp_rdata, rsp_rdata_i);
        end
        if (rsp_ready_i) begin
          pend = 1'b0;
          rsp_cnt_o++;
        end
      end
      if (req_valid_i && req_ready_i) begin
        if (pend_before) report_failure("request accepted with a response outstanding");
        acc_cnt_o++;
        route = switch_active_i ? ROUTE_EXT : ROUTE_INT;
        idx   = req_addr_i[`MEM_OFS_W +: `MEM_IDX_W];
        if (ext_req_valid_i !== (route == ROUTE_EXT)) begin
          report_mismatch("ext_route", route == ROUTE_EXT, ext_req_valid_i);
        end else if (route == ROUTE_EXT) begin
          if (ext_req_we_i !== req_we_i) report_mismatch("ext_we", req_we_i, ext_req_we_i);
          if (ext_req_addr_i !== req_addr_i) begin
            report_mismatch("ext_addr", req_addr_i, ext_req_addr_i);
          end
          if (ext_req_be_i !== req_be_i) report_mismatch("ext_be", req_be_i, ext_req_be_i);
          if (ext_req_wdata_i !== req_wdata_i) begin
            report_mismatch("ext_wdata", req_wdata_i, ext_req_wdata_i);
          end
        end
        if (req_we_i) begin
          exp_rdata = '0;
          if (route == ROUTE_EXT) begin
            ext_mem[idx] = merge_bytes(ext_mem[idx], req_wdata_i, req_be_i);
          end else begin
            int_mem[idx] = merge_bytes(int_mem[idx], req_wdata_i, req_be_i);
            wword.raw = req_wdata_i;
            // Tohost word in either alias; the first done write sets the code
            if ({req_addr_i[11:2], 2'b00} == 12'hFF0 && wword.fields.done && !exp_exit) begin
              exp_exit = 1'b1;
              exp_code = wword.fields.code;
            end
          end
        end else begin
          exp_rdata = (route == ROUTE_EXT) ? ext_mem[idx] : int_mem[idx];
        end
        pend     = 1'b1;
        pend_ext = (route == ROUTE_EXT);
      end
    end
  end

endmodule

// ==== tb/mem_subsys_checker.sv ====
// Handshake and reset assertions, bound onto the subsystem top level
// Assumes at most one request outstanding between acceptance and response
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_subsys_checker (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   req_valid_i,
  input logic                   req_ready_o,
  input logic                   rsp_valid_o,
  input logic                   rsp_ready_i,
  input logic [`MEM_DATA_W-1:0] rsp_rdata_o,
  input logic                   ext_req_valid_o,
  input logic                   ext_req_ready_i,
  input logic                   ext_req_we_o,
  input logic [`MEM_ADDR_W-1:0] ext_req_addr_o,
  input logic [`MEM_BE_W-1:0]   ext_req_be_o,
  input logic [`MEM_DATA_W-1:0] ext_req_wdata_o,
  input logic                   exit_valid_o
);

  int fail_cnt = 0;
  int outstanding_q;

  // Requests accepted minus responses taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(req_valid_i & req_ready_o)
                       - int'(rsp_valid_o & rsp_ready_i);
    end
  end

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o))
    else begin
      $error("response valid or data changed before it was taken");
      fail_cnt++;
    end

  a_ext_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    ext_req_valid_o && !ext_req_ready_i |=> ext_req_valid_o &&
    $stable({ext_req_we_o, ext_req_addr_o, ext_req_be_o, ext_req_wdata_o}))
    else begin
      $error("external request dropped or changed before it was accepted");
      fail_cnt++;
    end

  // Idle outputs right after a reset cycle
  a_reset_idle: assert property (@(posedge clk_i)
    rst_i |=> req_ready_o && !rsp_valid_o && !ext_req_valid_o && !exit_valid_o)
    else begin
      $error("outputs not idle after reset");
      fail_cnt++;
    end

  a_single: assert property (@(posedge clk_i) disable iff (rst_i) outstanding_q <= 1)
    else begin
      $error("more than one request outstanding");
      fail_cnt++;
    end

endmodule

bind mem_subsys_top mem_subsys_checker chk (.*);

// ==== tb/mem_subsys_tb.sv ====
// Random traffic over both routes with back-pressure and a slow external slave
// Switch select only changes when a new request is issued
`timescale 1ns/1ns
`include "mem_defines.svh"

module mem_subsys_tb;

  localparam int N_TXN   = 400;
  localparam int MAX_DLY = 4;
  // Generous cycle budget per transaction for the watchdog
  localparam int TXN_CYC = 8 * (MAX_DLY + 4);

  logic        clk_i = 1'b0;
  logic        rst_i = 1'b1;
  logic        switch_active_i = 1'b0;
  logic        req_valid_i = 1'b0;
  logic        req_we_i = 1'b0;
  logic [31:0] req_addr_i = '0;
  logic [3:0]  req_be_i = '0;
  logic [31:0] req_wdata_i = '0;
  logic        rsp_ready_i = 1'b0;
  logic        ext_req_ready_i = 1'b0;
  logic        ext_rsp_valid_i = 1'b0;
  logic [31:0] ext_rsp_rdata_i = '0;
  logic        req_ready_o, rsp_valid_o, ext_req_valid_o, ext_req_we_o, ext_rsp_ready_o;
  logic [31:0] rsp_rdata_o, ext_req_addr_o, ext_req_wdata_o;
  logic [3:0]  ext_req_be_o;
  logic        exit_valid_o;
  logic [30:0] exit_code_o;
  int          err_cnt, acc_cnt, rsp_cnt;
  int          n_sent = 0;
  int          ext_wait;
  logic        ext_busy = 1'b0;
  logic [31:0] ext_mem [1024] = '{default: '0};
  logic [9:0]  ext_idx;
  int          total_err;

  mem_subsys_top dut (.*);

  mem_scoreboard u_sb (
    .clk_i (clk_i), .rst_i (rst_i), .switch_active_i (switch_active_i),
    .req_valid_i (req_valid_i), .req_ready_i (req_ready_o), .req_we_i (req_we_i),
    .req_addr_i (req_addr_i), .req_be_i (req_be_i), .req_wdata_i (req_wdata_i),
    .rsp_valid_i (rsp_valid_o), .rsp_ready_i (rsp_ready_i), .rsp_rdata_i (rsp_rdata_o),
    .ext_req_valid_i (ext_req_valid_o), .ext_req_we_i (ext_req_we_o),
    .ext_req_addr_i (ext_req_addr_o), .ext_req_be_i (ext_req_be_o),
    .ext_req_wdata_i (ext_req_wdata_o), .ext_rsp_ready_i (ext_rsp_ready_o),
    .exit_valid_i (exit_valid_o), .exit_code_i (exit_code_o),
    .err_cnt_o (err_cnt), .acc_cnt_o (acc_cnt), .rsp_cnt_o (rsp_cnt)
  );

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Upstream request driver
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (!req_valid_i || req_ready_o) begin
        if (n_sent < N_TXN && $urandom_range(3) != 0) begin
          n_sent++;
          req_valid_i     <= 1'b1;
          switch_active_i <= ($urandom_range(1) == 1);
          req_we_i        <= ($urandom_range(1) == 1);
          req_be_i        <= 4'($urandom_range(15));
          req_wdata_i     <= $urandom;
          // Two aliased images, a few hot words and the tohost word
          if ($urandom_range(7) == 0) begin
            req_addr_i <= {19'd0, 1'($urandom_range(1)), 12'hFF0};
          end else begin
            req_addr_i <= {19'd0, 1'($urandom_range(1)), 6'd0, 4'($urandom_range(15)), 2'b00};
          end
        end else begin
          req_valid_i <= 1'b0;
        end
      end
      rsp_ready_i <= ($urandom_range(3) != 0);
    end
  end

  // --------------------------------------------------------------------------
  // External slave model with its own memory
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_i) begin
      ext_req_ready_i <= 1'b0;
      ext_rsp_valid_i <= 1'b0;
      ext_busy = 1'b0;
    end else if (ext_rsp_valid_i) begin
      if (ext_rsp_ready_o) ext_rsp_valid_i <= 1'b0;
    end else if (ext_busy) begin
      if (ext_wait == 0) begin
        ext_rsp_valid_i <= 1'b1;
        ext_busy = 1'b0;
      end else begin
        ext_wait--;
      end
    end else if (ext_req_valid_o && ext_req_ready_i) begin
      ext_idx = ext_req_addr_o[11:2];
      if (ext_req_we_o) begin
        for (int b = 0; b < 4; b++) begin
          if (ext_req_be_o[b]) ext_mem[ext_idx][b*8 +: 8] = ext_req_wdata_o[b*8 +: 8];
        end
        ext_rsp_rdata_i <= '0;
      end else begin
        ext_rsp_rdata_i <= ext_mem[ext_idx];
      end
      ext_req_ready_i <= 1'b0;
      ext_busy = 1'b1;
      ext_wait = $urandom_range(MAX_DLY);
    end else begin
      ext_req_ready_i <= ($urandom_range(1) == 1);
    end
  end

  // Watchdog
  initial begin
    #((N_TXN * TXN_CYC + 100) * 10);
    $display("Watchdog expired with %0d of %0d responses seen", rsp_cnt, N_TXN);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(32'hcd2e_0f65));
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    wait (rsp_cnt == N_TXN);
    repeat (4) @(posedge clk_i);
    total_err = err_cnt + dut.chk.fail_cnt;
    if (acc_cnt != rsp_cnt) begin
      $display("ERROR accepted requests and responses differ in number");
      total_err++;
    end
    $display("Requests %0d, responses %0d, scoreboard errors %0d, assertion failures %0d",
             acc_cnt, rsp_cnt, err_cnt, dut.chk.fail_cnt);
    if (total_err == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
